//--- instr_pkg.sv
`default_nettype none

package instr;

    // Data path and register file geometry
    localparam int XLEN      = 32;
    localparam int NUM_REGS  = 32;
    localparam int REG_IDX_W = $clog2(NUM_REGS);
    localparam int SHAMT_W   = $clog2(XLEN);

    typedef logic [XLEN-1:0]      t_rv_reg_data;
    typedef logic [REG_IDX_W-1:0] t_rv_reg_idx;

    // Major opcodes handled by this slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // ALU funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef enum logic [3:0] {
        U_ADD,
        U_SUB,
        U_AND,
        U_XOR,
        U_OR,
        U_SLL,
        U_SRL,
        U_SRA,
        U_SLT,
        U_SLTU,
        U_LUI,
        U_AUIPC,
        U_ILLEGAL
    } t_uop;

    // Decoded instruction as seen by EX0
    typedef struct packed {
        t_uop         uop;
        t_rv_reg_idx  rd;
        t_rv_reg_idx  rs1;
        t_rv_reg_idx  rs2;
        t_rv_reg_data imm;
        logic         use_imm;
        t_rv_reg_data pc;
    } t_uinstr;

endpackage

`default_nettype wire

//--- instr_intake.sv
`timescale 1ns/100ps
`default_nettype none

module instr_intake (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_req,
    input  logic [31:0]        in_instr,
    input  instr::t_rv_reg_data in_pc,
    input  logic               busy,
    output logic               in_ack,
    output logic               iss_ex0,
    output logic [31:0]        instr_ex0,
    output instr::t_rv_reg_data pc_ex0
);

    typedef enum logic [1:0] {
        S_WAIT_REQ,
        S_ISSUED,
        S_WAIT_REL
    } t_state;

    t_state state;
    logic   capture;

    // New request, previous one fully released, retire side idle
    assign capture = (state == S_WAIT_REQ) && in_req && !in_ack && !busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_WAIT_REQ;
            in_ack  <= 1'b0;
            iss_ex0 <= 1'b0;
        end else begin
            case (state)
                S_WAIT_REQ: begin
                    if (capture) begin
                        state   <= S_ISSUED;
                        in_ack  <= 1'b1;
                        iss_ex0 <= 1'b1;
                    end
                end
                S_ISSUED: begin
                    iss_ex0 <= 1'b0;
                    // Sender may already have dropped req
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        state  <= S_WAIT_REQ;
                    end else begin
                        state <= S_WAIT_REL;
                    end
                end
                default: begin
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        state  <= S_WAIT_REQ;
                    end
                end
            endcase
        end
    end

    // Instruction and pc held for the EX0 cycle
    always_ff @(posedge clk) begin
        if (capture) begin
            instr_ex0 <= in_instr;
            pc_ex0    <= in_pc;
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req)
    ) else $error("in_ack rose without in_req");

endmodule

`default_nettype wire

//--- decode.sv
`timescale 1ns/100ps
`default_nettype none

module decode (
    input  logic                iss_ex0,
    input  logic [31:0]         instr_ex0,
    input  instr::t_rv_reg_data pc_ex0,
    output instr::t_uinstr      uinstr_ex0
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                funct7_b30;
    instr::t_rv_reg_data imm_i;
    instr::t_rv_reg_data imm_u;
    instr::t_uop         alu_uop;

    assign opcode     = instr_ex0[6:0];
    assign funct3     = instr_ex0[14:12];
    assign funct7_b30 = instr_ex0[30];

    // I-type sign extended, U-type upper 20 bits
    assign imm_i = {{(instr::XLEN-12){instr_ex0[31]}}, instr_ex0[31:20]};
    assign imm_u = {instr_ex0[31:12], 12'b0};

    // ALU op shared by OP and OP-IMM, SUB only exists in OP
    always_comb begin
        case (funct3)
            instr::F3_ADD_SUB: begin
                if ((opcode == instr::OPC_OP) && funct7_b30) begin
                    alu_uop = instr::U_SUB;
                end else begin
                    alu_uop = instr::U_ADD;
                end
            end
            instr::F3_SLL:  alu_uop = instr::U_SLL;
            instr::F3_SLT:  alu_uop = instr::U_SLT;
            instr::F3_SLTU: alu_uop = instr::U_SLTU;
            instr::F3_XOR:  alu_uop = instr::U_XOR;
            instr::F3_SRL_SRA: begin
                alu_uop = funct7_b30 ? instr::U_SRA : instr::U_SRL;
            end
            instr::F3_OR:   alu_uop = instr::U_OR;
            instr::F3_AND:  alu_uop = instr::U_AND;
            default:        alu_uop = instr::U_ILLEGAL;
        endcase
    end

    always_comb begin
        uinstr_ex0.uop     = instr::U_ILLEGAL;
        uinstr_ex0.rd      = '0;
        uinstr_ex0.rs1     = instr_ex0[19:15];
        uinstr_ex0.rs2     = instr_ex0[24:20];
        uinstr_ex0.imm     = imm_i;
        uinstr_ex0.use_imm = 1'b0;
        uinstr_ex0.pc      = pc_ex0;
        case (opcode)
            instr::OPC_OP: begin
                uinstr_ex0.uop = alu_uop;
                uinstr_ex0.rd  = instr_ex0[11:7];
            end
            instr::OPC_OP_IMM: begin
                uinstr_ex0.uop     = alu_uop;
                uinstr_ex0.rd      = instr_ex0[11:7];
                uinstr_ex0.use_imm = 1'b1;
            end
            instr::OPC_LUI: begin
                uinstr_ex0.uop     = instr::U_LUI;
                uinstr_ex0.rd      = instr_ex0[11:7];
                uinstr_ex0.rs1     = '0;
                uinstr_ex0.imm     = imm_u;
                uinstr_ex0.use_imm = 1'b1;
            end
            instr::OPC_AUIPC: begin
                uinstr_ex0.uop     = instr::U_AUIPC;
                uinstr_ex0.rd      = instr_ex0[11:7];
                uinstr_ex0.rs1     = '0;
                uinstr_ex0.imm     = imm_u;
                uinstr_ex0.use_imm = 1'b1;
            end
            // Illegal keeps rd at zero so nothing can be written
            default: begin
                uinstr_ex0.uop = instr::U_ILLEGAL;
            end
        endcase
    end

    always_comb begin
        if (iss_ex0) begin
            a_uop_known: assert final (!$isunknown(uinstr_ex0.uop))
                else $error("decode produced an unknown uop");
        end
    end

endmodule

`default_nettype wire

//--- operand_read.sv
`timescale 1ns/100ps
`default_nettype none

module operand_read (
    input  logic                clk,
    input  logic                arst_n,
    input  instr::t_uinstr      uinstr_ex0,
    input  logic                wr_en,
    input  instr::t_rv_reg_idx  wr_idx,
    input  instr::t_rv_reg_data wr_data,
    output instr::t_rv_reg_data src1val_ex0,
    output instr::t_rv_reg_data src2val_ex0
);

    instr::t_rv_reg_data regs [instr::NUM_REGS];
    instr::t_rv_reg_data rs2val;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < instr::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // x0 is hardwired to zero
    assign src1val_ex0 = (uinstr_ex0.rs1 == '0) ? '0 : regs[uinstr_ex0.rs1];
    assign rs2val      = (uinstr_ex0.rs2 == '0) ? '0 : regs[uinstr_ex0.rs2];

    // Immediate replaces rs2 for OP-IMM, LUI and AUIPC
    assign src2val_ex0 = uinstr_ex0.use_imm ? uinstr_ex0.imm : rs2val;

endmodule

`default_nettype wire

//--- ialu.sv
`timescale 1ns/100ps
`default_nettype none

module ialu (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                iss_ex0,
    input  instr::t_uinstr      uinstr_ex0,
    input  instr::t_rv_reg_data src1val_ex0,
    input  instr::t_rv_reg_data src2val_ex0,
    output logic                resvld_ex0,
    output instr::t_rv_reg_data result_ex0
);

    logic signed [instr::XLEN-1:0] src1val_signed;
    logic signed [instr::XLEN-1:0] src2val_signed;
    logic [instr::SHAMT_W-1:0]     shamt;

    assign src1val_signed = src1val_ex0;
    assign src2val_signed = src2val_ex0;
    assign shamt          = src2val_ex0[instr::SHAMT_W-1:0];

    always_comb begin
        result_ex0 = '0;
        resvld_ex0 = iss_ex0;
        case (uinstr_ex0.uop)
            instr::U_ADD:  result_ex0 = src1val_ex0 + src2val_ex0;
            instr::U_SUB:  result_ex0 = src1val_ex0 - src2val_ex0;
            instr::U_AND:  result_ex0 = src1val_ex0 & src2val_ex0;
            instr::U_XOR:  result_ex0 = src1val_ex0 ^ src2val_ex0;
            instr::U_OR:   result_ex0 = src1val_ex0 | src2val_ex0;
            instr::U_SLL:  result_ex0 = src1val_ex0 << shamt;
            instr::U_SRL:  result_ex0 = src1val_ex0 >> shamt;
            instr::U_SRA:  result_ex0 = src1val_signed >>> shamt;
            instr::U_SLT: begin
                result_ex0 = instr::t_rv_reg_data'(src1val_signed < src2val_signed);
            end
            instr::U_SLTU: begin
                result_ex0 = instr::t_rv_reg_data'(src1val_ex0 < src2val_ex0);
            end
            // Source two already carries the upper immediate
            instr::U_LUI:   result_ex0 = src2val_ex0;
            instr::U_AUIPC: result_ex0 = src2val_ex0 + uinstr_ex0.pc;
            default: begin
                resvld_ex0 = 1'b0;
                result_ex0 = '0;
            end
        endcase
    end

    // One result per issue, the issue pulse lasts a single cycle
    a_resvld_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        resvld_ex0 |=> !resvld_ex0
    ) else $error("ialu result valid on two consecutive cycles");

endmodule

`default_nettype wire

//--- retire.sv
`timescale 1ns/100ps
`default_nettype none

module retire (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                iss_ex0,
    input  instr::t_uinstr      uinstr_ex0,
    input  logic                resvld_ex0,
    input  instr::t_rv_reg_data result_ex0,
    input  logic                res_ack,
    output logic                res_req,
    output instr::t_rv_reg_idx  res_rd,
    output instr::t_rv_reg_data res_value,
    output logic                res_illegal,
    output logic                busy,
    output logic                wr_en,
    output instr::t_rv_reg_idx  wr_idx,
    output instr::t_rv_reg_data wr_data
);

    // Register file write lands on the same edge the result is latched
    assign wr_en   = iss_ex0 && resvld_ex0 && (uinstr_ex0.rd != '0);
    assign wr_idx  = uinstr_ex0.rd;
    assign wr_data = result_ex0;

    // Result port handshake and busy toward intake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_req <= 1'b0;
            busy    <= 1'b0;
        end else if (iss_ex0) begin
            res_req <= 1'b1;
            busy    <= 1'b1;
        end else if (res_req && res_ack) begin
            res_req <= 1'b0;
        end else if (busy && !res_req && !res_ack) begin
            // Ack seen low again, handshake complete
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_ex0) begin
            res_rd      <= uinstr_ex0.rd;
            res_value   <= resvld_ex0 ? result_ex0 : '0;
            res_illegal <= (uinstr_ex0.uop == instr::U_ILLEGAL);
        end
    end

    a_res_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        res_req && $past(res_req) |-> $stable({res_rd, res_value, res_illegal})
    ) else $error("result payload changed while res_req high");

endmodule

`default_nettype wire

//--- int_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module int_core_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_req,
    input  logic [31:0]         in_instr,
    input  instr::t_rv_reg_data in_pc,
    output logic                in_ack,
    output logic                res_req,
    output instr::t_rv_reg_idx  res_rd,
    output instr::t_rv_reg_data res_value,
    output logic                res_illegal,
    input  logic                res_ack
);

    logic                iss_ex0;
    logic [31:0]         instr_ex0;
    instr::t_rv_reg_data pc_ex0;
    instr::t_uinstr      uinstr_ex0;
    instr::t_rv_reg_data src1val_ex0;
    instr::t_rv_reg_data src2val_ex0;
    logic                resvld_ex0;
    instr::t_rv_reg_data result_ex0;
    logic                busy;
    logic                wr_en;
    instr::t_rv_reg_idx  wr_idx;
    instr::t_rv_reg_data wr_data;

    instr_intake intake_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_req    (in_req),
        .in_instr  (in_instr),
        .in_pc     (in_pc),
        .busy      (busy),
        .in_ack    (in_ack),
        .iss_ex0   (iss_ex0),
        .instr_ex0 (instr_ex0),
        .pc_ex0    (pc_ex0)
    );

    decode decode_inst (
        .iss_ex0    (iss_ex0),
        .instr_ex0  (instr_ex0),
        .pc_ex0     (pc_ex0),
        .uinstr_ex0 (uinstr_ex0)
    );

    operand_read operand_read_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .uinstr_ex0  (uinstr_ex0),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .src1val_ex0 (src1val_ex0),
        .src2val_ex0 (src2val_ex0)
    );

    ialu ialu_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .iss_ex0     (iss_ex0),
        .uinstr_ex0  (uinstr_ex0),
        .src1val_ex0 (src1val_ex0),
        .src2val_ex0 (src2val_ex0),
        .resvld_ex0  (resvld_ex0),
        .result_ex0  (result_ex0)
    );

    retire retire_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .iss_ex0     (iss_ex0),
        .uinstr_ex0  (uinstr_ex0),
        .resvld_ex0  (resvld_ex0),
        .result_ex0  (result_ex0),
        .res_ack     (res_ack),
        .res_req     (res_req),
        .res_rd      (res_rd),
        .res_value   (res_value),
        .res_illegal (res_illegal),
        .busy        (busy),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data)
    );

endmodule

`default_nettype wire

//--- tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_req,
    input  logic [31:0]         in_instr,
    input  instr::t_rv_reg_data in_pc,
    input  logic                in_ack,
    input  logic                res_req,
    input  instr::t_rv_reg_idx  res_rd,
    input  instr::t_rv_reg_data res_value,
    input  logic                res_illegal,
    input  logic                res_ack,
    output int                  error_count,
    output int                  retire_count
);

    logic [31:0] model_regs [32];
    logic        prev_in_req;
    logic        prev_in_ack;
    logic        prev_res_req;
    logic        prev_res_ack;
    logic [31:0] prev_instr;
    logic [31:0] prev_pc;
    logic        pending;
    logic        res_open;
    int          cycle;
    int          ack_cycle;
    logic [4:0]  exp_rd;
    logic [31:0] exp_value;
    logic        exp_illegal;
    string       exp_name;

    initial begin
        error_count  = 0;
        retire_count = 0;
    end

    task automatic show_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        $display("MISMATCH %s: expected %h, actual %h", what, exp, act);
        error_count++;
    endtask

    task automatic protocol_error(input string msg);
        $display("ERROR at cycle %0d: %s", cycle, msg);
        error_count++;
    endtask

    // Expected outcome from the RV32I rules, then the model register write
    function automatic void predict(input logic [31:0] word, input logic [31:0] pc);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        opc = word[6:0];
        f3  = word[14:12];
        alt = word[30];
        a   = model_regs[word[19:15]];
        b   = (opc == instr::OPC_OP) ? model_regs[word[24:20]]
                                     : {{20{word[31]}}, word[31:20]};
        sh  = b[4:0];
        exp_rd      = word[11:7];
        exp_illegal = 1'b0;
        if (opc == instr::OPC_LUI) begin
            exp_value = {word[31:12], 12'h000};
            exp_name  = "LUI";
        end else if (opc == instr::OPC_AUIPC) begin
            exp_value = pc + {word[31:12], 12'h000};
            exp_name  = "AUIPC";
        end else if (opc == instr::OPC_OP || opc == instr::OPC_OP_IMM) begin
            case (f3)
                3'b000: begin
                    exp_value = (opc == instr::OPC_OP && alt) ? a - b : a + b;
                    exp_name  = (opc == instr::OPC_OP && alt) ? "SUB" : "ADD";
                end
                3'b001: begin
                    exp_value = a << sh;
                    exp_name  = "SLL";
                end
                3'b010: begin
                    // Signed compare by flipping the sign bits
                    exp_value = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
                    exp_name  = "SLT";
                end
                3'b011: begin
                    exp_value = {31'b0, a < b};
                    exp_name  = "SLTU";
                end
                3'b100: begin
                    exp_value = a ^ b;
                    exp_name  = "XOR";
                end
                3'b101: begin
                    exp_value = a >> sh;
                    exp_name  = "SRL";
                    if (alt) begin
                        exp_value = exp_value | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
                        exp_name  = "SRA";
                    end
                end
                3'b110: begin
                    exp_value = a | b;
                    exp_name  = "OR";
                end
                default: begin
                    exp_value = a & b;
                    exp_name  = "AND";
                end
            endcase
            if (opc == instr::OPC_OP_IMM) begin
                exp_name = {exp_name, "I"};
            end
        end else begin
            exp_illegal = 1'b1;
            exp_rd      = 5'd0;
            exp_value   = 32'h0;
            exp_name    = "ILLEGAL";
        end
        if (!exp_illegal && exp_rd != 5'd0) begin
            model_regs[exp_rd] = exp_value;
        end
    endfunction

    always @(posedge clk) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = 32'h0;
            end
            pending   = 1'b0;
            res_open  = 1'b0;
            cycle     = 0;
            ack_cycle = 0;
        end else begin
            cycle++;
            // Instruction port
            if (in_ack && !prev_in_ack) begin
                if (!prev_in_req) begin
                    protocol_error("in_ack rose while in_req was low");
                end
                if (pending || res_open) begin
                    protocol_error("in_ack rose before the previous result handshake ended");
                end
                predict(prev_instr, prev_pc);
                pending   = 1'b1;
                ack_cycle = cycle;
            end
            if (!in_ack && prev_in_ack && prev_in_req) begin
                protocol_error("in_ack dropped while in_req was still high");
            end
            // Result port
            if (res_req && !prev_res_req) begin
                if (!pending) begin
                    protocol_error("res_req rose with no accepted instruction");
                end else begin
                    if (res_rd != exp_rd) begin
                        show_mismatch({exp_name, " rd"}, 32'(exp_rd), 32'(res_rd));
                    end
                    if (res_value != exp_value) begin
                        show_mismatch({exp_name, " value"}, exp_value, res_value);
                    end
                    if (res_illegal != exp_illegal) begin
                        show_mismatch({exp_name, " illegal"}, 32'(exp_illegal),
                                      32'(res_illegal));
                    end
                    if (cycle != ack_cycle + 1) begin
                        protocol_error("res_req did not rise one cycle after in_ack");
                    end
                end
                if (prev_res_ack) begin
                    protocol_error("res_req rose while res_ack was still high");
                end
                retire_count++;
                pending  = 1'b0;
                res_open = 1'b1;
            end
            if (!res_req && prev_res_req && !prev_res_ack) begin
                protocol_error("res_req dropped before res_ack was raised");
            end
            if (res_open && !res_req && !res_ack && prev_res_ack) begin
                res_open = 1'b0;
            end
        end
        prev_in_req  = in_req;
        prev_in_ack  = in_ack;
        prev_res_req = res_req;
        prev_res_ack = res_ack;
        prev_instr   = in_instr;
        prev_pc      = in_pc;
    end

endmodule

`default_nettype wire

//--- tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = NUM_INSTR * 16 + 100;

    logic                clk;
    logic                arst_n;
    logic                in_req;
    logic [31:0]         in_instr;
    instr::t_rv_reg_data in_pc;
    logic                in_ack;
    logic                res_req;
    instr::t_rv_reg_idx  res_rd;
    instr::t_rv_reg_data res_value;
    logic                res_illegal;
    logic                res_ack;
    int                  error_count;
    int                  retire_count;
    int                  cycle_count;

    int_core_top int_core_top_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_req      (in_req),
        .in_instr    (in_instr),
        .in_pc       (in_pc),
        .in_ack      (in_ack),
        .res_req     (res_req),
        .res_rd      (res_rd),
        .res_value   (res_value),
        .res_illegal (res_illegal),
        .res_ack     (res_ack)
    );

    tb_checker checker_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_req       (in_req),
        .in_instr     (in_instr),
        .in_pc        (in_pc),
        .in_ack       (in_ack),
        .res_req      (res_req),
        .res_rd       (res_rd),
        .res_value    (res_value),
        .res_illegal  (res_illegal),
        .res_ack      (res_ack),
        .error_count  (error_count),
        .retire_count (retire_count)
    );

    always #5 clk = ~clk;

    // Mostly x0..x7 so results feed later instructions
    function automatic logic [4:0] pick_reg();
        if ($urandom_range(3) != 0) begin
            return 5'($urandom_range(7));
        end
        return 5'($urandom_range(31));
    endfunction

    function automatic logic [31:0] make_instr();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  opc;
        logic [11:0] imm12;
        logic [31:0] word;
        f3    = 3'($urandom_range(7));
        f7    = 7'h00;
        word  = $urandom();
        imm12 = word[31:20];
        // SUB and SRA need bit 30, every other funct7 stays zero
        if ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1) == 1) begin
            f7 = 7'h20;
        end
        case ($urandom_range(9))
            0, 1, 2, 3: begin
                word = {f7, pick_reg(), pick_reg(), f3, pick_reg(), instr::OPC_OP};
            end
            4, 5, 6: begin
                if (f3 == 3'b001) begin
                    imm12 = {7'h00, word[24:20]};
                end else if (f3 == 3'b101) begin
                    imm12 = {f7, word[24:20]};
                end
                word = {imm12, pick_reg(), f3, pick_reg(), instr::OPC_OP_IMM};
            end
            7: word = {word[31:12], pick_reg(), instr::OPC_LUI};
            8: word = {word[31:12], pick_reg(), instr::OPC_AUIPC};
            default: begin
                opc = 7'($urandom_range(127));
                while (opc == instr::OPC_OP || opc == instr::OPC_OP_IMM ||
                       opc == instr::OPC_LUI || opc == instr::OPC_AUIPC) begin
                    opc = 7'($urandom_range(127));
                end
                word = {word[31:7], opc};
            end
        endcase
        return word;
    endfunction

    // Instruction driver, four-phase sender
    initial begin
        void'($urandom(32'h921a_9d5a));
        clk         = 1'b0;
        arst_n      = 1'b0;
        in_req      = 1'b0;
        in_instr    = '0;
        in_pc       = '0;
        res_ack     = 1'b0;
        cycle_count = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < NUM_INSTR; i++) begin
            repeat ($urandom_range(3)) @(negedge clk);
            in_instr = make_instr();
            in_pc    = $urandom() & 32'hffff_fffc;
            in_req   = 1'b1;
            @(negedge clk);
            while (!in_ack) @(negedge clk);
            in_req = 1'b0;
            @(negedge clk);
            while (in_ack) @(negedge clk);
        end
        // Let the last result handshake finish
        while (retire_count < NUM_INSTR || res_req || res_ack) @(negedge clk);
        repeat (2) @(negedge clk);
        $display("Run complete: %0d instructions retired, %0d errors",
                 retire_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Result port responder with a random ack delay
    initial begin
        forever begin
            @(negedge clk);
            if (arst_n && res_req && !res_ack) begin
                repeat ($urandom_range(3)) @(negedge clk);
                res_ack = 1'b1;
                @(negedge clk);
                while (res_req) @(negedge clk);
                res_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles: %0d of %0d retired, %0d errors",
                     cycle_count, retire_count, NUM_INSTR, error_count);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim.f
instr_pkg.sv
instr_intake.sv
decode.sv
operand_read.sv
ialu.sv
retire.sv
int_core_top.sv
tb_checker.sv
tb_top.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_top \
    -f sim.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
